//--- vlog.f
+incdir+bench
verilog/csr_pkg.sv
verilog/trap_pkg.sv
verilog/csr_access.sv
verilog/trap_csrs.sv
verilog/timer_csrs.sv
verilog/csr_top.sv
bench/tb_csr.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_csr
FILELIST  := vlog.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^TEST OK$$" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/tb_csr_model.svh
`ifndef TB_CSR_MODEL_SVH
`define TB_CSR_MODEL_SVH

// Cycle-level reference of the kept CSRs and the timer
logic [31:0] m_crmd;
logic [31:0] m_prmd;
logic [31:0] m_ecfg;
logic [1:0]  m_is_sw;
logic [5:0]  m_ecode;
logic [8:0]  m_esubcode;
logic [31:0] m_era;
logic [31:0] m_badv;
logic [31:0] m_eentry;
logic [31:0] m_save [SAVE_COUNT];
logic [31:0] m_tid;
logic [31:0] m_tcfg;
logic [31:0] m_count;
logic        m_timer_irq;

task automatic reset_model();
    m_crmd      = 32'h0000_0008;
    m_prmd      = 32'h0;
    m_ecfg      = 32'h0;
    m_is_sw     = 2'b00;
    m_tid       = 32'h0;
    m_tcfg      = 32'h0;
    m_count     = 32'hffff_ffff;
    m_timer_irq = 1'b0;
endtask

function automatic logic [31:0] expected_read(input csr_num_t num);
    logic [31:0] v;
    v = 32'h0;
    case (num)
        CSR_CRMD:   v = m_crmd;
        CSR_PRMD:   v = m_prmd;
        CSR_ECFG:   v = m_ecfg;
        CSR_ESTAT: begin
            v[1:0]   = m_is_sw;
            v[11]    = m_timer_irq;
            v[21:16] = m_ecode;
            v[30:22] = m_esubcode;
        end
        CSR_ERA:    v = m_era;
        CSR_BADV:   v = m_badv;
        CSR_EENTRY: v = m_eentry;
        CSR_TID:    v = m_tid;
        CSR_TCFG:   v = m_tcfg;
        CSR_TVAL:   v = m_count;
        default: begin
            for (int i = 0; i < SAVE_COUNT; i++) begin
                if (num == CSR_SAVE0 + csr_num_t'(i))
                    v = m_save[i];
            end
        end
    endcase
    return v;
endfunction

function automatic logic expected_has_int();
    logic [12:0] is_bits;
    is_bits = 13'h0;
    is_bits[1:0] = m_is_sw;
    is_bits[11] = m_timer_irq;
    return (|(is_bits & m_ecfg[12:0])) && m_crmd[2];
endfunction

// Advance one clock edge with the inputs of the cycle just ended
task automatic step_model(input csr_req_t req, input trap_evt_t tr);
    logic [31:0] merged;
    logic [31:0] count_next;
    logic        irq_next;
    merged = (req.wvalue & req.wmask) | (expected_read(req.num) & ~req.wmask);
    irq_next = m_timer_irq;
    if (m_count == 32'h0)
        irq_next = 1'b1;
    else if (req.we && req.num == CSR_TICLR && merged[0])
        irq_next = 1'b0;
    count_next = m_count;
    if (req.we && req.num == CSR_TCFG && merged[0]) begin
        count_next = {merged[31:2], 2'b00};
    end else if (m_tcfg[0] && m_count != 32'hffff_ffff) begin
        if (m_count == 32'h0 && m_tcfg[1])
            count_next = {m_tcfg[31:2], 2'b00};
        else
            count_next = m_count - 32'd1;
    end
    m_timer_irq = irq_next;
    m_count = count_next;
    if (req.we && req.num == CSR_TCFG)
        m_tcfg = merged;
    if (req.we && req.num == CSR_TID)
        m_tid = merged;
    if (tr.ex) begin
        m_prmd = {29'h0, m_crmd[2:0]};
        m_crmd[2:0] = 3'b000;
        m_ecode = tr.ecode;
        m_esubcode = tr.esubcode;
        m_era = tr.pc;
        if (tr.ecode == ECODE_ADE && tr.esubcode == ESUBCODE_ADEF)
            m_badv = tr.pc;
        else if (tr.ecode == ECODE_ADE || tr.ecode == ECODE_ALE)
            m_badv = tr.vaddr;
    end else if (tr.ertn) begin
        m_crmd[2:0] = m_prmd[2:0];
    end else if (req.we) begin
        case (req.num)
            CSR_CRMD:   m_crmd = merged & 32'h0000_01ff;
            CSR_PRMD:   m_prmd = merged & 32'h0000_0007;
            CSR_ECFG:   m_ecfg = merged & 32'h0000_1bff;
            CSR_ESTAT:  m_is_sw = merged[1:0];
            CSR_ERA:    m_era = merged;
            CSR_BADV:   m_badv = merged;
            CSR_EENTRY: m_eentry = merged & 32'hffff_ffc0;
            default: begin
                for (int i = 0; i < SAVE_COUNT; i++) begin
                    if (req.num == CSR_SAVE0 + csr_num_t'(i))
                        m_save[i] = merged;
                end
            end
        endcase
    end
endtask

`endif

//--- bench/tb_csr.sv
`timescale 1ns/1ps
`default_nettype none

module tb_csr;

    import csr_pkg::*;
    import trap_pkg::*;

    localparam int SAVE_COUNT = 6;
    localparam trap_evt_t NO_TRAP = '0;

    logic        clk;
    logic        reset;
    csr_req_t    csr_req;
    trap_evt_t   trap;
    logic [31:0] csr_rvalue;
    logic [31:0] ex_entry;
    logic [31:0] era_pc;
    logic        has_int;

    logic [31:0] lcg_state;
    logic [31:0] last_rvalue;
    logic        outputs_valid;

    `include "tb_csr_model.svh"

    csr_top #(
        .SAVE_COUNT (SAVE_COUNT)
    ) DUT (
        .clk        (clk),
        .reset      (reset),
        .csr_req    (csr_req),
        .trap       (trap),
        .csr_rvalue (csr_rvalue),
        .ex_entry   (ex_entry),
        .era_pc     (era_pc),
        .has_int    (has_int)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [31:0] random_word();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = next_random();
        lo = next_random();
        return {hi[31:16], lo[31:16]};
    endfunction

    function automatic csr_num_t random_num();
        logic [31:0] r;
        csr_num_t    n;
        r = (next_random() >> 16) % 32'd18;
        case (r)
            0, 16:   n = CSR_CRMD;
            1:       n = CSR_PRMD;
            2, 15:   n = CSR_ECFG;
            3:       n = CSR_ESTAT;
            4:       n = CSR_ERA;
            5:       n = CSR_BADV;
            6:       n = CSR_EENTRY;
            7:       n = CSR_TID;
            8:       n = CSR_TCFG;
            9:       n = CSR_TVAL;
            10:      n = CSR_TICLR;
            // One past the last SAVE slot is unmapped
            11, 12:  n = CSR_SAVE0 + csr_num_t'((next_random() >> 16) % (SAVE_COUNT + 1));
            13:      n = 14'h002;
            14:      n = 14'h043;
            default: n = csr_num_t'(next_random() >> 18);
        endcase
        return n;
    endfunction

    function automatic csr_req_t make_req(input csr_num_t num, input logic we,
                                          input logic [31:0] value, input logic [31:0] mask);
        csr_req_t req;
        req.num = num;
        req.we = we;
        req.wvalue = value;
        req.wmask = mask;
        return req;
    endfunction

    function automatic csr_req_t read_req(input csr_num_t num);
        return make_req(num, 1'b0, 32'h0, 32'h0);
    endfunction

    function automatic trap_evt_t ex_trap(input logic [5:0] ecode, input logic [8:0] esubcode,
                                          input logic [31:0] pc, input logic [31:0] vaddr);
        trap_evt_t tr;
        tr = '0;
        tr.ex = 1'b1;
        tr.ecode = ecode;
        tr.esubcode = esubcode;
        tr.pc = pc;
        tr.vaddr = vaddr;
        return tr;
    endfunction

    function automatic trap_evt_t ertn_trap();
        trap_evt_t tr;
        tr = '0;
        tr.ertn = 1'b1;
        return tr;
    endfunction

    function automatic trap_evt_t random_exception();
        logic [31:0] r;
        logic [5:0]  code;
        logic [8:0]  sub;
        r = next_random();
        case ((r >> 16) % 32'd6)
            0:       code = ECODE_INT;
            1:       code = ECODE_ADE;
            2:       code = ECODE_ALE;
            3:       code = ECODE_SYS;
            4:       code = ECODE_BRK;
            default: code = ECODE_INE;
        endcase
        sub = r[24:16];
        if (code == ECODE_ADE && r[31])
            sub = ESUBCODE_ADEF;
        return ex_trap(code, sub, random_word(), random_word());
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    // Entered and left 2 ns after a rising edge
    task automatic run_cycle(input csr_req_t req, input trap_evt_t tr);
        csr_req = req;
        trap = tr;
        #1;
        last_rvalue = csr_rvalue;
        if (outputs_valid || !req.we)
            check_value("csr_rvalue", csr_rvalue, expected_read(req.num));
        if (outputs_valid) begin
            check_value("ex_entry", ex_entry, m_eentry);
            check_value("era_pc", era_pc, m_era);
        end
        check_value("has_int", {31'h0, has_int}, {31'h0, expected_has_int()});
        @(posedge clk);
        step_model(req, tr);
        #2;
    endtask

    task automatic wait_timer_irq(input int limit);
        int n;
        n = 0;
        last_rvalue = 32'h0;
        while (!last_rvalue[11]) begin
            if (n == limit) begin
                $display("Timer interrupt did not show up in ESTAT within %0d cycles", limit);
                $display("TEST FAILED");
                $fatal(1);
            end
            run_cycle(read_req(CSR_ESTAT), NO_TRAP);
            n++;
        end
    endtask

    initial begin
        int          op;
        logic [31:0] value;
        logic [31:0] r;
        csr_num_t    num;
        lcg_state = 32'd13;
        outputs_valid = 1'b0;
        last_rvalue = 32'h0;
        reset = 1'b1;
        csr_req = '0;
        trap = '0;
        reset_model();
        repeat (3) @(posedge clk);
        #2;
        reset = 1'b0;

        run_cycle(read_req(CSR_CRMD), NO_TRAP);
        check_value("crmd after reset", last_rvalue, 32'h0000_0008);
        run_cycle(read_req(CSR_TVAL), NO_TRAP);
        check_value("tval after reset", last_rvalue, 32'hffff_ffff);
        run_cycle(read_req(CSR_TICLR), NO_TRAP);
        check_value("ticlr after reset", last_rvalue, 32'h0);
        check_value("has_int after reset", {31'h0, has_int}, 32'h0);

        // Registers without reset get known values first
        run_cycle(make_req(CSR_ERA, 1'b1, random_word(), 32'hffff_ffff), NO_TRAP);
        run_cycle(make_req(CSR_BADV, 1'b1, random_word(), 32'hffff_ffff), NO_TRAP);
        run_cycle(make_req(CSR_EENTRY, 1'b1, random_word(), 32'hffff_ffff), NO_TRAP);
        for (int i = 0; i < SAVE_COUNT; i++) begin
            num = CSR_SAVE0 + csr_num_t'(i);
            run_cycle(make_req(num, 1'b1, random_word(), 32'hffff_ffff), NO_TRAP);
        end

        run_cycle(make_req(CSR_CRMD, 1'b1, 32'h7, 32'h7), NO_TRAP);
        value = random_word();
        run_cycle(read_req(CSR_CRMD), ex_trap(ECODE_ADE, ESUBCODE_ADEF, value, ~value));
        outputs_valid = 1'b1;
        run_cycle(read_req(CSR_PRMD), NO_TRAP);
        check_value("prmd after exception", last_rvalue, 32'h7);
        check_value("era_pc after exception", era_pc, value);
        run_cycle(read_req(CSR_BADV), NO_TRAP);
        check_value("badv after fetch fault", last_rvalue, value);
        run_cycle(read_req(CSR_CRMD), ertn_trap());
        check_value("crmd plv/ie in handler", last_rvalue & 32'h7, 32'h0);
        run_cycle(read_req(CSR_CRMD), NO_TRAP);
        check_value("crmd plv/ie after ertn", last_rvalue & 32'h7, 32'h7);

        repeat (400) begin
            op = int'((next_random() >> 16) % 32'd100);
            num = random_num();
            if (op < 40) begin
                run_cycle(read_req(num), NO_TRAP);
            end else if (op < 75) begin
                run_cycle(make_req(num, 1'b1, random_word(), random_word()), NO_TRAP);
                run_cycle(read_req(num), NO_TRAP);
            end else if (op < 83) begin
                run_cycle(read_req(num), random_exception());
                run_cycle(read_req(CSR_ESTAT), NO_TRAP);
                run_cycle(read_req(CSR_BADV), NO_TRAP);
            end else if (op < 90) begin
                run_cycle(read_req(num), ertn_trap());
            end else begin
                run_cycle('0, NO_TRAP);
            end
        end

        // One-shot timer with INITVAL 3
        run_cycle(make_req(CSR_TCFG, 1'b1, 32'h0000_000d, 32'hffff_ffff), NO_TRAP);
        run_cycle(make_req(CSR_TICLR, 1'b1, 32'h1, 32'h1), NO_TRAP);
        repeat (6) run_cycle(read_req(CSR_TVAL), NO_TRAP);
        wait_timer_irq(40);
        run_cycle(make_req(CSR_TICLR, 1'b1, 32'h1, 32'h1), NO_TRAP);
        run_cycle(read_req(CSR_ESTAT), NO_TRAP);
        check_value("estat timer bit after clear", {31'h0, last_rvalue[11]}, 32'h0);
        run_cycle(read_req(CSR_TVAL), NO_TRAP);
        check_value("tval after one-shot expiry", last_rvalue, 32'hffff_ffff);

        // Periodic timer with INITVAL 2
        run_cycle(make_req(CSR_TCFG, 1'b1, 32'h0000_000b, 32'hffff_ffff), NO_TRAP);
        run_cycle(make_req(CSR_TICLR, 1'b1, 32'h1, 32'h1), NO_TRAP);
        wait_timer_irq(40);
        run_cycle(make_req(CSR_TICLR, 1'b1, 32'h1, 32'h1), NO_TRAP);
        run_cycle(read_req(CSR_ESTAT), NO_TRAP);
        check_value("estat timer bit after clear", {31'h0, last_rvalue[11]}, 32'h0);
        wait_timer_irq(40);
        run_cycle(read_req(CSR_TVAL), NO_TRAP);

        // Interrupt enables against software and timer sources
        repeat (100) begin
            r = next_random();
            case (r[17:16])
                2'd0:    run_cycle(make_req(CSR_ECFG, 1'b1, random_word(), 32'hffff_ffff),
                                   NO_TRAP);
                2'd1:    run_cycle(make_req(CSR_ESTAT, 1'b1, random_word(), 32'h3), NO_TRAP);
                2'd2:    run_cycle(make_req(CSR_CRMD, 1'b1, random_word(), 32'h4), NO_TRAP);
                default: run_cycle(make_req(CSR_TICLR, 1'b1, 32'h1, 32'h1), NO_TRAP);
            endcase
            run_cycle(read_req(CSR_ESTAT), NO_TRAP);
        end

        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/csr_top.sv
`timescale 1ns/1ps
`default_nettype none

module csr_top #(
    parameter int SAVE_COUNT = 4
) (
    input  logic                clk,
    input  logic                reset,
    input  csr_pkg::csr_req_t   csr_req,
    input  trap_pkg::trap_evt_t trap,
    output logic [31:0]         csr_rvalue,
    output logic [31:0]         ex_entry,
    output logic [31:0]         era_pc,
    output logic                has_int
);

    import csr_pkg::*;

    csr_wr_t      csr_wr;
    trap_rdata_t  trap_rdata;
    timer_rdata_t timer_rdata;
    logic         timer_irq;

    csr_access #(
        .SAVE_COUNT (SAVE_COUNT)
    ) u_access (
        .clk         (clk),
        .csr_req     (csr_req),
        .trap_rdata  (trap_rdata),
        .timer_rdata (timer_rdata),
        .csr_wr      (csr_wr),
        .csr_rvalue  (csr_rvalue)
    );

    trap_csrs #(
        .SAVE_COUNT (SAVE_COUNT)
    ) u_trap (
        .clk        (clk),
        .reset      (reset),
        .csr_wr     (csr_wr),
        .trap       (trap),
        .timer_irq  (timer_irq),
        .trap_rdata (trap_rdata),
        .ex_entry   (ex_entry),
        .era_pc     (era_pc),
        .has_int    (has_int)
    );

    timer_csrs u_timer (
        .clk         (clk),
        .reset       (reset),
        .csr_wr      (csr_wr),
        .timer_rdata (timer_rdata),
        .timer_irq   (timer_irq)
    );

endmodule

`default_nettype wire

//--- verilog/timer_csrs.sv
`timescale 1ns/1ps
`default_nettype none

module timer_csrs (
    input  logic                  clk,
    input  logic                  reset,
    input  csr_pkg::csr_wr_t      csr_wr,
    output csr_pkg::timer_rdata_t timer_rdata,
    output logic                  timer_irq
);

    import csr_pkg::*;

    logic [31:0] tid;
    logic        tcfg_en;
    logic        tcfg_periodic;
    logic [29:0] tcfg_initval;
    logic [31:0] count;
    logic        load;
    logic        ticlr;

    // Load takes EN from the merged word
    assign load  = csr_wr.sel.tcfg && csr_wr.data[TCFG_EN];
    assign ticlr = csr_wr.sel.ticlr && csr_wr.data[TICLR_CLR];

    always_ff @(posedge clk) begin
        if (reset) begin
            tid           <= 32'b0;
            tcfg_en       <= 1'b0;
            tcfg_periodic <= 1'b0;
            tcfg_initval  <= 30'b0;
        end else begin
            if (csr_wr.sel.tid)
                tid <= csr_wr.data;
            if (csr_wr.sel.tcfg) begin
                tcfg_en       <= csr_wr.data[TCFG_EN];
                tcfg_periodic <= csr_wr.data[TCFG_PERIODIC];
                tcfg_initval  <= csr_wr.data[TCFG_INITVAL +: 30];
            end
        end
    end

    // All ones means stopped; one-shot mode wraps there from zero
    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '1;
        end else if (load) begin
            count <= {csr_wr.data[TCFG_INITVAL +: 30], 2'b00};
        end else if (tcfg_en && count != '1) begin
            if (count == '0 && tcfg_periodic)
                count <= {tcfg_initval, 2'b00};
            else
                count <= count - 32'd1;
        end
    end

    // Expiry wins over a clear in the same cycle
    always_ff @(posedge clk) begin
        if (reset)
            timer_irq <= 1'b0;
        else if (count == '0)
            timer_irq <= 1'b1;
        else if (ticlr)
            timer_irq <= 1'b0;
    end

    always_comb begin
        timer_rdata = '0;
        timer_rdata.tid                         = tid;
        timer_rdata.tcfg[TCFG_EN]               = tcfg_en;
        timer_rdata.tcfg[TCFG_PERIODIC]         = tcfg_periodic;
        timer_rdata.tcfg[TCFG_INITVAL +: 30]    = tcfg_initval;
        timer_rdata.tval                        = count;
    end

endmodule

`default_nettype wire

//--- verilog/trap_csrs.sv
`timescale 1ns/1ps
`default_nettype none

module trap_csrs #(
    parameter int SAVE_COUNT = 4
) (
    input  logic                 clk,
    input  logic                 reset,
    input  csr_pkg::csr_wr_t     csr_wr,
    input  trap_pkg::trap_evt_t  trap,
    input  logic                 timer_irq,
    output csr_pkg::trap_rdata_t trap_rdata,
    output logic [31:0]          ex_entry,
    output logic [31:0]          era_pc,
    output logic                 has_int
);

    import csr_pkg::*;
    import trap_pkg::*;

    logic [1:0]  crmd_plv;
    logic        crmd_ie;
    logic        crmd_da;
    logic        crmd_pg;
    logic [1:0]  crmd_datf;
    logic [1:0]  crmd_datm;
    logic [1:0]  prmd_pplv;
    logic        prmd_pie;
    logic [12:0] ecfg_lie;
    logic [1:0]  estat_is_sw;
    logic [12:0] estat_is;
    logic [5:0]  estat_ecode;
    logic [8:0]  estat_esubcode;
    logic [31:0] era;
    logic [31:0] badv;
    logic [25:0] eentry_va;
    logic [31:0] save [SAVE_COUNT];
    logic        addr_err;

    // Mode bits, exception entry and return take priority over writes
    always_ff @(posedge clk) begin
        if (reset) begin
            crmd_plv  <= 2'b00;
            crmd_ie   <= 1'b0;
            crmd_da   <= 1'b1;
            crmd_pg   <= 1'b0;
            crmd_datf <= 2'b00;
            crmd_datm <= 2'b00;
        end else if (trap.ex) begin
            crmd_plv <= 2'b00;
            crmd_ie  <= 1'b0;
        end else if (trap.ertn) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (csr_wr.sel.crmd) begin
            crmd_plv  <= csr_wr.data[CRMD_PLV +: 2];
            crmd_ie   <= csr_wr.data[CRMD_IE];
            crmd_da   <= csr_wr.data[CRMD_DA];
            crmd_pg   <= csr_wr.data[CRMD_PG];
            crmd_datf <= csr_wr.data[CRMD_DATF +: 2];
            crmd_datm <= csr_wr.data[CRMD_DATM +: 2];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            prmd_pplv <= 2'b00;
            prmd_pie  <= 1'b0;
        end else if (trap.ex) begin
            prmd_pplv <= crmd_plv;
            prmd_pie  <= crmd_ie;
        end else if (csr_wr.sel.prmd) begin
            prmd_pplv <= csr_wr.data[PRMD_PPLV +: 2];
            prmd_pie  <= csr_wr.data[PRMD_PIE];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ecfg_lie    <= 13'b0;
            estat_is_sw <= 2'b00;
        end else begin
            if (csr_wr.sel.ecfg)
                ecfg_lie <= csr_wr.data[ECFG_LIE +: 13] & ECFG_LIE_WMASK;
            if (csr_wr.sel.estat)
                estat_is_sw <= csr_wr.data[ESTAT_IS_SW +: 2];
        end
    end

    assign addr_err = (trap.ecode == ECODE_ADE) || (trap.ecode == ECODE_ALE);

    always_ff @(posedge clk) begin
        if (trap.ex) begin
            estat_ecode    <= trap.ecode;
            estat_esubcode <= trap.esubcode;
            era            <= trap.pc;
        end else if (csr_wr.sel.era) begin
            era <= csr_wr.data;
        end
        // Fetch faults report the pc itself
        if (trap.ex && addr_err)
            badv <= (trap.ecode == ECODE_ADE && trap.esubcode == ESUBCODE_ADEF) ?
                    trap.pc : trap.vaddr;
        else if (csr_wr.sel.badv)
            badv <= csr_wr.data;
        if (csr_wr.sel.eentry)
            eentry_va <= csr_wr.data[EENTRY_VA +: 26];
    end

    for (genvar i = 0; i < SAVE_COUNT; i++) begin : g_save
        always_ff @(posedge clk) begin
            if (csr_wr.sel.save[i])
                save[i] <= csr_wr.data;
        end
    end

    always_comb begin
        estat_is = '0;
        estat_is[ESTAT_IS_SW +: 2] = estat_is_sw;
        estat_is[ESTAT_IS_TI] = timer_irq;
    end

    always_comb begin
        trap_rdata = '0;
        trap_rdata.crmd[CRMD_PLV +: 2]         = crmd_plv;
        trap_rdata.crmd[CRMD_IE]               = crmd_ie;
        trap_rdata.crmd[CRMD_DA]               = crmd_da;
        trap_rdata.crmd[CRMD_PG]               = crmd_pg;
        trap_rdata.crmd[CRMD_DATF +: 2]        = crmd_datf;
        trap_rdata.crmd[CRMD_DATM +: 2]        = crmd_datm;
        trap_rdata.prmd[PRMD_PPLV +: 2]        = prmd_pplv;
        trap_rdata.prmd[PRMD_PIE]              = prmd_pie;
        trap_rdata.ecfg[ECFG_LIE +: 13]        = ecfg_lie;
        trap_rdata.estat[ESTAT_IS +: 13]       = estat_is;
        trap_rdata.estat[ESTAT_ECODE +: 6]     = estat_ecode;
        trap_rdata.estat[ESTAT_ESUBCODE +: 9]  = estat_esubcode;
        trap_rdata.era                         = era;
        trap_rdata.badv                        = badv;
        trap_rdata.eentry[EENTRY_VA +: 26]     = eentry_va;
        for (int i = 0; i < SAVE_COUNT; i++) begin
            trap_rdata.save[i] = save[i];
        end
    end

    assign ex_entry = trap_rdata.eentry;
    assign era_pc   = era;
    assign has_int  = (|(estat_is & ecfg_lie)) && crmd_ie;

    a_ex_ertn_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(trap.ex && trap.ertn))
        else $error("exception and ERTN strobes in the same cycle");

endmodule

`default_nettype wire

//--- verilog/csr_access.sv
`timescale 1ns/1ps
`default_nettype none

module csr_access #(
    parameter int SAVE_COUNT = 4
) (
    input  logic                  clk,
    input  csr_pkg::csr_req_t     csr_req,
    input  csr_pkg::trap_rdata_t  trap_rdata,
    input  csr_pkg::timer_rdata_t timer_rdata,
    output csr_pkg::csr_wr_t      csr_wr,
    output logic [31:0]           csr_rvalue
);

    import csr_pkg::*;

    csr_sel_t    sel;
    logic [31:0] rdata;

    always_comb begin
        sel = '0;
        case (csr_req.num)
            CSR_CRMD:   sel.crmd   = 1'b1;
            CSR_PRMD:   sel.prmd   = 1'b1;
            CSR_ECFG:   sel.ecfg   = 1'b1;
            CSR_ESTAT:  sel.estat  = 1'b1;
            CSR_ERA:    sel.era    = 1'b1;
            CSR_BADV:   sel.badv   = 1'b1;
            CSR_EENTRY: sel.eentry = 1'b1;
            CSR_TID:    sel.tid    = 1'b1;
            CSR_TCFG:   sel.tcfg   = 1'b1;
            CSR_TVAL:   sel.tval   = 1'b1;
            CSR_TICLR:  sel.ticlr  = 1'b1;
            default: ;
        endcase
        // Only the implemented SAVE slots decode
        for (int i = 0; i < SAVE_COUNT; i++) begin
            if (csr_req.num == CSR_SAVE0 + csr_num_t'(i))
                sel.save[i] = 1'b1;
        end
    end

    // TICLR has no readable state
    always_comb begin
        rdata = ({32{sel.crmd}}   & trap_rdata.crmd)
              | ({32{sel.prmd}}   & trap_rdata.prmd)
              | ({32{sel.ecfg}}   & trap_rdata.ecfg)
              | ({32{sel.estat}}  & trap_rdata.estat)
              | ({32{sel.era}}    & trap_rdata.era)
              | ({32{sel.badv}}   & trap_rdata.badv)
              | ({32{sel.eentry}} & trap_rdata.eentry)
              | ({32{sel.tid}}    & timer_rdata.tid)
              | ({32{sel.tcfg}}   & timer_rdata.tcfg)
              | ({32{sel.tval}}   & timer_rdata.tval);
        for (int i = 0; i < SAVE_COUNT; i++) begin
            rdata = rdata | ({32{sel.save[i]}} & trap_rdata.save[i]);
        end
    end

    assign csr_rvalue = rdata;

    // Masked merge against the current value
    assign csr_wr.data = (csr_req.wvalue & csr_req.wmask) | (rdata & ~csr_req.wmask);
    assign csr_wr.sel  = csr_req.we ? sel : '0;

    a_sel_onehot: assert property (@(posedge clk) $onehot0(sel))
        else $error("CSR number decoded to more than one register");

endmodule

`default_nettype wire

//--- verilog/trap_pkg.sv
`default_nettype none

package trap_pkg;

    // Exception codes
    localparam logic [5:0] ECODE_INT = 6'h00;
    localparam logic [5:0] ECODE_ADE = 6'h08;
    localparam logic [5:0] ECODE_ALE = 6'h09;
    localparam logic [5:0] ECODE_SYS = 6'h0b;
    localparam logic [5:0] ECODE_BRK = 6'h0c;
    localparam logic [5:0] ECODE_INE = 6'h0d;

    // Fetch address error
    localparam logic [8:0] ESUBCODE_ADEF = 9'h000;

    // Exception or return reported by writeback
    typedef struct packed {
        logic        ex;
        logic        ertn;
        logic [5:0]  ecode;
        logic [8:0]  esubcode;
        logic [31:0] pc;
        logic [31:0] vaddr;
    } trap_evt_t;

endpackage

`default_nettype wire

//--- verilog/csr_pkg.sv
`default_nettype none

package csr_pkg;

    localparam int MAX_SAVE = 16;

    typedef logic [13:0] csr_num_t;

    // CSR numbers
    localparam csr_num_t CSR_CRMD   = 14'h000;
    localparam csr_num_t CSR_PRMD   = 14'h001;
    localparam csr_num_t CSR_ECFG   = 14'h004;
    localparam csr_num_t CSR_ESTAT  = 14'h005;
    localparam csr_num_t CSR_ERA    = 14'h006;
    localparam csr_num_t CSR_BADV   = 14'h007;
    localparam csr_num_t CSR_EENTRY = 14'h00c;
    localparam csr_num_t CSR_SAVE0  = 14'h030;
    localparam csr_num_t CSR_TID    = 14'h040;
    localparam csr_num_t CSR_TCFG   = 14'h041;
    localparam csr_num_t CSR_TVAL   = 14'h042;
    localparam csr_num_t CSR_TICLR  = 14'h044;

    // Field LSB positions
    localparam int CRMD_PLV       = 0;
    localparam int CRMD_IE        = 2;
    localparam int CRMD_DA        = 3;
    localparam int CRMD_PG        = 4;
    localparam int CRMD_DATF      = 5;
    localparam int CRMD_DATM      = 7;
    localparam int PRMD_PPLV      = 0;
    localparam int PRMD_PIE       = 2;
    localparam int ECFG_LIE       = 0;
    localparam int ESTAT_IS       = 0;
    localparam int ESTAT_IS_SW    = 0;
    localparam int ESTAT_IS_TI    = 11;
    localparam int ESTAT_ECODE    = 16;
    localparam int ESTAT_ESUBCODE = 22;
    localparam int EENTRY_VA      = 6;
    localparam int TCFG_EN        = 0;
    localparam int TCFG_PERIODIC  = 1;
    localparam int TCFG_INITVAL   = 2;
    localparam int TICLR_CLR      = 0;

    // Bit 10 of LIE has no source
    localparam logic [12:0] ECFG_LIE_WMASK = 13'h1bff;

    typedef struct packed {
        csr_num_t    num;
        logic        we;
        logic [31:0] wvalue;
        logic [31:0] wmask;
    } csr_req_t;

    typedef struct packed {
        logic [MAX_SAVE-1:0] save;
        logic                ticlr;
        logic                tval;
        logic                tcfg;
        logic                tid;
        logic                eentry;
        logic                badv;
        logic                era;
        logic                estat;
        logic                ecfg;
        logic                prmd;
        logic                crmd;
    } csr_sel_t;

    typedef struct packed {
        csr_sel_t    sel;
        logic [31:0] data;
    } csr_wr_t;

    typedef struct packed {
        logic [MAX_SAVE-1:0][31:0] save;
        logic [31:0]               eentry;
        logic [31:0]               badv;
        logic [31:0]               era;
        logic [31:0]               estat;
        logic [31:0]               ecfg;
        logic [31:0]               prmd;
        logic [31:0]               crmd;
    } trap_rdata_t;

    typedef struct packed {
        logic [31:0] tval;
        logic [31:0] tcfg;
        logic [31:0] tid;
    } timer_rdata_t;

endpackage

`default_nettype wire
